// File: Bender.yml
package:
  name: eeprom_master

sources:
  - eeprom_pkg.sv
  - eeprom_apb_regs.sv
  - eeprom_xfer_ctrl.sv
  - i2c_bit_engine.sv
  - eeprom_master_top.sv
  - target: test
    files:
      - tb_eeprom_model.sv
      - tb_eeprom_master.sv

// File: eeprom_apb_regs.sv
`timescale 1ns/100ps
`default_nettype none

module eeprom_apb_regs
    import eeprom_pkg::*;
(
    input  wire logic         CLK,
    input  wire logic         RESET,
    input  wire logic         psel,
    input  wire logic         penable,
    input  wire logic         pwrite,
    input  wire apb_addr_t    paddr,
    input  wire apb_data_t    pwdata,
    output apb_data_t         prdata,
    output logic              pready,
    output logic              pslverr,
    output logic              start_wr,
    output logic              start_rd,
    output eeprom_addr_t      eeprom_addr,
    output eeprom_byte_t      wdata,
    input  wire logic         busy,
    input  wire logic         job_done,
    input  wire logic         job_nack,
    input  wire eeprom_byte_t rdata
);

    logic         access;
    logic         ctrl_go;
    logic         job_pending;
    logic         bad_access;
    logic         wr_done;
    logic         rd_done;
    logic         ctrl_wr;
    logic         done_q;
    logic         nack_q;
    eeprom_byte_t rdata_q;

    assign access      = psel & penable;
    assign job_pending = busy | start_wr | start_rd;  // covers the gap before busy rises
    assign ctrl_go     = access & pwrite & (paddr == REG_CTRL) & (pwdata[0] | pwdata[1]);
    assign pready      = ~(ctrl_go & job_pending);

    always_comb
    begin
        case (paddr)
            REG_CTRL:   bad_access = ~pwrite;
            REG_ADDR,
            REG_WDATA:  bad_access = 1'b0;
            REG_STATUS,
            REG_RDATA:  bad_access = pwrite;
            default:    bad_access = 1'b1;
        endcase
    end

    assign pslverr = access & pready & bad_access;
    assign wr_done = access & pready & pwrite & ~bad_access;
    assign rd_done = access & ~pwrite & ~bad_access;
    assign ctrl_wr = wr_done & (paddr == REG_CTRL);

    always_comb
    begin
        prdata = '0;
        case (paddr)
            REG_ADDR:   prdata[10:0] = eeprom_addr;
            REG_WDATA:  prdata[7:0]  = wdata;
            REG_STATUS: prdata[2:0]  = {nack_q, done_q, job_pending};
            REG_RDATA:  prdata[7:0]  = rdata_q;
            default:    prdata       = '0;
        endcase
    end

    always_ff @(posedge CLK)
    begin
        if (RESET)
        begin
            start_wr    <= 1'b0;
            start_rd    <= 1'b0;
            eeprom_addr <= '0;
            wdata       <= '0;
            done_q      <= 1'b0;
            nack_q      <= 1'b0;
        end
        else
        begin
            start_wr <= ctrl_wr & pwdata[0];
            start_rd <= ctrl_wr & pwdata[1] & ~pwdata[0];  // write wins
            if (wr_done && paddr == REG_ADDR)
                eeprom_addr <= pwdata[10:0];
            if (wr_done && paddr == REG_WDATA)
                wdata <= pwdata[7:0];
            if (rd_done && paddr == REG_STATUS)
            begin
                done_q <= 1'b0;
                nack_q <= 1'b0;
            end
            if (job_done)  // a finishing job beats the clear
            begin
                done_q <= 1'b1;
                nack_q <= job_nack;
            end
        end
    end

    always_ff @(posedge CLK)
    begin
        if (job_done)
            rdata_q <= rdata;
    end

endmodule

`default_nettype wire

// File: eeprom_master_top.sv
`timescale 1ns/100ps
`default_nettype none

module eeprom_master_top
    import eeprom_pkg::*;
#(
    parameter int CLK_DIV = 4
)
(
    input  wire logic      CLK,
    input  wire logic      RESET,
    input  wire logic      psel,
    input  wire logic      penable,
    input  wire logic      pwrite,
    input  wire apb_addr_t paddr,
    input  wire apb_data_t pwdata,
    output apb_data_t      prdata,
    output logic           pready,
    output logic           pslverr,
    output logic           scl,
    inout  wire            sda
);

    logic         start_wr;
    logic         start_rd;
    eeprom_addr_t eeprom_addr;
    eeprom_byte_t wdata;
    logic         busy;
    logic         job_done;
    logic         job_nack;
    eeprom_byte_t rdata;
    bit_cmd_e     cmd;
    eeprom_byte_t tx_byte;
    logic         ack_send;
    logic         cmd_valid;
    logic         cmd_ready;
    logic         cmd_done;
    eeprom_byte_t rx_byte;
    logic         ack_rcvd;

    eeprom_apb_regs i_regs (
        .CLK         (CLK),
        .RESET       (RESET),
        .psel        (psel),
        .penable     (penable),
        .pwrite      (pwrite),
        .paddr       (paddr),
        .pwdata      (pwdata),
        .prdata      (prdata),
        .pready      (pready),
        .pslverr     (pslverr),
        .start_wr    (start_wr),
        .start_rd    (start_rd),
        .eeprom_addr (eeprom_addr),
        .wdata       (wdata),
        .busy        (busy),
        .job_done    (job_done),
        .job_nack    (job_nack),
        .rdata       (rdata)
    );

    eeprom_xfer_ctrl i_ctrl (
        .CLK         (CLK),
        .RESET       (RESET),
        .start_wr    (start_wr),
        .start_rd    (start_rd),
        .eeprom_addr (eeprom_addr),
        .wdata       (wdata),
        .busy        (busy),
        .job_done    (job_done),
        .job_nack    (job_nack),
        .rdata       (rdata),
        .cmd         (cmd),
        .tx_byte     (tx_byte),
        .ack_send    (ack_send),
        .cmd_valid   (cmd_valid),
        .cmd_ready   (cmd_ready),
        .cmd_done    (cmd_done),
        .rx_byte     (rx_byte),
        .ack_rcvd    (ack_rcvd)
    );

    i2c_bit_engine #(
        .CLK_DIV (CLK_DIV)
    ) i_engine (
        .CLK       (CLK),
        .RESET     (RESET),
        .cmd       (cmd),
        .tx_byte   (tx_byte),
        .ack_send  (ack_send),
        .cmd_valid (cmd_valid),
        .cmd_ready (cmd_ready),
        .cmd_done  (cmd_done),
        .rx_byte   (rx_byte),
        .ack_rcvd  (ack_rcvd),
        .scl       (scl),
        .sda       (sda)
    );

endmodule

`default_nettype wire

// File: eeprom_pkg.sv
`default_nettype none

package eeprom_pkg;

    typedef logic [10:0] eeprom_addr_t;  // byte address inside a 24C16
    typedef logic [7:0]  eeprom_byte_t;
    typedef logic [4:0]  apb_addr_t;
    typedef logic [31:0] apb_data_t;

    // apb register map
    localparam apb_addr_t REG_CTRL   = 5'h00;  // bit 0 write, bit 1 read
    localparam apb_addr_t REG_ADDR   = 5'h04;
    localparam apb_addr_t REG_WDATA  = 5'h08;
    localparam apb_addr_t REG_STATUS = 5'h0C;  // busy, done, nack
    localparam apb_addr_t REG_RDATA  = 5'h10;

    localparam logic [3:0] EEPROM_DEV_CODE = 4'b1010;

    typedef enum logic [1:0] {
        CMD_START,  // start or repeated start
        CMD_WRITE,  // byte out, ack in
        CMD_READ,   // byte in, ack out
        CMD_STOP
    } bit_cmd_e;

    typedef enum logic [3:0] {
        XS_IDLE,
        XS_START,
        XS_CTRL_WR,
        XS_ADDR_WR,
        XS_DATA_WR,
        XS_RESTART,
        XS_CTRL_RD,
        XS_DATA_RD,
        XS_STOP,
        XS_FINISH
    } xfer_state_e;

    typedef enum logic [1:0] {
        BS_IDLE,
        BS_START,
        BS_BIT,
        BS_STOP
    } bit_state_e;

endpackage

`default_nettype wire

// File: eeprom_xfer_ctrl.sv
`timescale 1ns/100ps
`default_nettype none

module eeprom_xfer_ctrl
    import eeprom_pkg::*;
(
    input  wire logic         CLK,
    input  wire logic         RESET,
    input  wire logic         start_wr,
    input  wire logic         start_rd,
    input  wire eeprom_addr_t eeprom_addr,
    input  wire eeprom_byte_t wdata,
    output logic              busy,
    output logic              job_done,
    output logic              job_nack,
    output eeprom_byte_t      rdata,
    output bit_cmd_e          cmd,
    output eeprom_byte_t      tx_byte,
    output logic              ack_send,
    output logic              cmd_valid,
    input  wire logic         cmd_ready,
    input  wire logic         cmd_done,
    input  wire eeprom_byte_t rx_byte,
    input  wire logic         ack_rcvd
);

    xfer_state_e  state;
    logic         rd_job;
    logic         cmd_sent;   // command taken, waiting for cmd_done
    logic         nack_q;
    logic         cmd_state;
    eeprom_addr_t job_addr;
    eeprom_byte_t job_wdata;

    assign cmd_state = (state != XS_IDLE) && (state != XS_FINISH);
    assign cmd_valid = cmd_state & ~cmd_sent;
    assign busy      = (state != XS_IDLE);
    assign job_done  = (state == XS_FINISH);
    assign job_nack  = nack_q;
    assign ack_send  = 1'b0;  // single byte read always ends with nack

    always_comb
    begin
        cmd     = CMD_WRITE;
        tx_byte = 8'hFF;
        case (state)
            XS_START,
            XS_RESTART: cmd     = CMD_START;
            XS_CTRL_WR: tx_byte = {EEPROM_DEV_CODE, job_addr[10:8], 1'b0};
            XS_ADDR_WR: tx_byte = job_addr[7:0];
            XS_DATA_WR: tx_byte = job_wdata;
            XS_CTRL_RD: tx_byte = {EEPROM_DEV_CODE, job_addr[10:8], 1'b1};
            XS_DATA_RD: cmd     = CMD_READ;
            XS_STOP:    cmd     = CMD_STOP;
            default:    cmd     = CMD_WRITE;
        endcase
    end

    always_ff @(posedge CLK)
    begin
        if (RESET)
        begin
            state    <= XS_IDLE;
            rd_job   <= 1'b0;
            cmd_sent <= 1'b0;
            nack_q   <= 1'b0;
        end
        else
        begin
            if (cmd_valid && cmd_ready)
                cmd_sent <= 1'b1;
            else if (cmd_done)
                cmd_sent <= 1'b0;

            // any written byte left unanswered aborts the job
            if (cmd_done && cmd == CMD_WRITE && !ack_rcvd)
                nack_q <= 1'b1;

            case (state)
                XS_IDLE:
                begin
                    if (start_wr || start_rd)
                    begin
                        rd_job <= start_rd & ~start_wr;
                        nack_q <= 1'b0;
                        state  <= XS_START;
                    end
                end
                XS_START:
                begin
                    if (cmd_done)
                        state <= XS_CTRL_WR;
                end
                XS_CTRL_WR:
                begin
                    if (cmd_done)
                        state <= ack_rcvd ? XS_ADDR_WR : XS_STOP;
                end
                XS_ADDR_WR:
                begin
                    if (cmd_done)
                    begin
                        if (!ack_rcvd)
                            state <= XS_STOP;
                        else
                            state <= rd_job ? XS_RESTART : XS_DATA_WR;
                    end
                end
                XS_DATA_WR:
                begin
                    if (cmd_done)
                        state <= XS_STOP;
                end
                XS_RESTART:
                begin
                    if (cmd_done)
                        state <= XS_CTRL_RD;
                end
                XS_CTRL_RD:
                begin
                    if (cmd_done)
                        state <= ack_rcvd ? XS_DATA_RD : XS_STOP;
                end
                XS_DATA_RD:
                begin
                    if (cmd_done)
                        state <= XS_STOP;
                end
                XS_STOP:
                begin
                    if (cmd_done)
                        state <= XS_FINISH;
                end
                default:
                    state <= XS_IDLE;  // finish lasts one cycle
            endcase
        end
    end

    // job parameters frozen for the whole transaction
    always_ff @(posedge CLK)
    begin
        if (state == XS_IDLE && (start_wr || start_rd))
        begin
            job_addr  <= eeprom_addr;
            job_wdata <= wdata;
        end
        if (state == XS_DATA_RD && cmd_done)
            rdata <= rx_byte;
    end

endmodule

`default_nettype wire

// File: i2c_bit_engine.sv
`timescale 1ns/100ps
`default_nettype none

module i2c_bit_engine
    import eeprom_pkg::*;
#(
    parameter int CLK_DIV = 4
)
(
    input  wire logic         CLK,
    input  wire logic         RESET,
    input  wire bit_cmd_e     cmd,
    input  wire eeprom_byte_t tx_byte,
    input  wire logic         ack_send,
    input  wire logic         cmd_valid,
    output logic              cmd_ready,
    output logic              cmd_done,
    output eeprom_byte_t      rx_byte,
    output logic              ack_rcvd,
    output logic              scl,
    inout  wire               sda
);

    localparam int QW = (CLK_DIV > 1) ? $clog2(CLK_DIV) : 1;

    bit_state_e    state;
    logic [QW-1:0] qcnt;
    logic [1:0]    phase;    // quarters 0,1 scl low, 2,3 scl high
    logic [3:0]    bitcnt;   // 8 is the ack slot
    logic          rd_op;
    logic          ack_out;
    logic          sda_low;
    logic          next_low;
    logic          tick;
    eeprom_byte_t  shreg;

    assign tick      = (qcnt == QW'(CLK_DIV - 1));
    assign cmd_ready = (state == BS_IDLE);
    assign rx_byte   = shreg;
    assign sda       = sda_low ? 1'b0 : 1'bz;  // open drain

    // sda level for the second quarter, while scl is low
    always_comb
    begin
        case (state)
            BS_START: next_low = 1'b0;  // released, also for a repeated start
            BS_STOP:  next_low = 1'b1;
            default:
            begin
                if (bitcnt == 4'd8)
                    next_low = rd_op & ack_out;
                else
                    next_low = ~rd_op & ~shreg[7];
            end
        endcase
    end

    always_ff @(posedge CLK)
    begin
        if (RESET)
        begin
            state    <= BS_IDLE;
            qcnt     <= '0;
            phase    <= 2'd0;
            bitcnt   <= 4'd0;
            scl      <= 1'b1;
            sda_low  <= 1'b0;
            cmd_done <= 1'b0;
        end
        else
        begin
            cmd_done <= 1'b0;
            if (state == BS_IDLE)
            begin
                if (cmd_valid)
                begin
                    qcnt   <= '0;
                    phase  <= 2'd0;
                    bitcnt <= 4'd0;
                    scl    <= 1'b0;  // every sequence opens with scl low
                    case (cmd)
                        CMD_START: state <= BS_START;
                        CMD_STOP:  state <= BS_STOP;
                        default:   state <= BS_BIT;
                    endcase
                end
            end
            else
            begin
                qcnt <= tick ? '0 : qcnt + QW'(1);
                if (tick)
                begin
                    phase <= phase + 2'd1;
                    case (phase)
                        2'd0: sda_low <= next_low;
                        2'd1: scl     <= 1'b1;
                        2'd2:
                        begin
                            // the only sda edges while scl is high
                            if (state == BS_START)
                                sda_low <= 1'b1;
                            else if (state == BS_STOP)
                                sda_low <= 1'b0;
                        end
                        default:
                        begin
                            if (state != BS_BIT || bitcnt == 4'd8)
                            begin
                                state    <= BS_IDLE;
                                cmd_done <= 1'b1;
                            end
                            else
                            begin
                                bitcnt <= bitcnt + 4'd1;
                                scl    <= 1'b0;
                            end
                        end
                    endcase
                end
            end
        end
    end

    // one shift register serves both directions
    always_ff @(posedge CLK)
    begin
        if (state == BS_IDLE && cmd_valid)
        begin
            shreg   <= tx_byte;
            rd_op   <= (cmd == CMD_READ);
            ack_out <= ack_send;
        end
        else if (state == BS_BIT && tick && phase == 2'd2)  // middle of scl high
        begin
            if (bitcnt == 4'd8)
                ack_rcvd <= ~sda;
            else
                shreg <= {shreg[6:0], sda};
        end
    end

endmodule

`default_nettype wire

// File: tb_eeprom_master.sv
`timescale 1ns/100ps
`default_nettype none

module tb_eeprom_master
    import eeprom_pkg::*;
();

    localparam int     CLK_DIV     = 2;
    localparam int     BIT_CYCLES  = 4 * CLK_DIV;
    localparam int     DONE_LIMIT  = 50 * BIT_CYCLES;
    localparam int     N_RANDOM    = 4;
    localparam int     N_JOBS      = 2 * (N_RANDOM + 2) + 2 + 1;
    localparam longint WATCHDOG_NS = N_JOBS * 60 * BIT_CYCLES * 4 + 4000;

    logic      CLK;
    logic      RESET;
    logic      psel;
    logic      penable;
    logic      pwrite;
    apb_addr_t paddr;
    apb_data_t pwdata;
    apb_data_t prdata;
    logic      pready;
    logic      pslverr;
    logic      scl;
    wire       sda;
    logic      nack_ctrl;

    int   errors       = 0;
    int   tests_passed = 0;
    int   tests_failed = 0;
    int   cycle_cnt    = 0;
    int   jobs_run     = 0;
    int   starts_exp   = 0;
    int   start_cnt    = 0;
    int   stop_cnt     = 0;
    int   scl_pulses   = 0;
    logic bus_busy     = 1'b0;
    int   seed;

    pullup (sda);

    eeprom_master_top #(
        .CLK_DIV (CLK_DIV)
    ) i_dut (
        .CLK     (CLK),
        .RESET   (RESET),
        .psel    (psel),
        .penable (penable),
        .pwrite  (pwrite),
        .paddr   (paddr),
        .pwdata  (pwdata),
        .prdata  (prdata),
        .pready  (pready),
        .pslverr (pslverr),
        .scl     (scl),
        .sda     (sda)
    );

    tb_eeprom_model i_model (
        .scl       (scl),
        .sda       (sda),
        .nack_ctrl (nack_ctrl)
    );

    initial
    begin
        CLK = 1'b0;
        forever #2 CLK = ~CLK;
    end

    always @(posedge CLK)
        cycle_cnt <= cycle_cnt + 1;

    task automatic bus_fault(input string what);
        $display("bus monitor at %0t ns: %s", $time, what);
        errors++;
    endtask

    // pulses before a start or stop must make whole bytes
    always @(posedge scl)
    begin
        if (RESET)
            scl_pulses = 0;
        else
        begin
            scl_pulses++;
            if (!bus_busy && scl_pulses > 1)
                bus_fault("SCL clocked a bit while no transfer was open");
        end
    end

    always @(sda)
    begin
        if (!RESET && scl === 1'b1)
        begin
            if (scl_pulses % 9 != 1)
                bus_fault("SDA changed while SCL was high inside a byte");
            if (sda === 1'b0)
            begin
                start_cnt++;
                bus_busy = 1'b1;
            end
            else
            begin
                if (!bus_busy)
                    bus_fault("stop condition without an open transfer");
                stop_cnt++;
                bus_busy = 1'b0;
            end
            scl_pulses = 0;
        end
    end

    task automatic apb_write(input apb_addr_t addr, input apb_data_t data,
                             output logic err, output int waits);
        @(posedge CLK);
        psel    <= 1'b1;
        penable <= 1'b0;
        pwrite  <= 1'b1;
        paddr   <= addr;
        pwdata  <= data;
        @(posedge CLK);
        penable <= 1'b1;
        waits = 0;
        @(negedge CLK);
        while (!pready && waits < DONE_LIMIT)
        begin
            waits++;
            @(negedge CLK);
        end
        if (!pready)
        begin
            $display("APB write to offset %h never completed, pready stayed low", addr);
            errors++;
        end
        err = pslverr;
        @(posedge CLK);
        psel    <= 1'b0;
        penable <= 1'b0;
    endtask

    task automatic apb_read(input apb_addr_t addr, output apb_data_t data, output logic err);
        @(posedge CLK);
        psel    <= 1'b1;
        penable <= 1'b0;
        pwrite  <= 1'b0;
        paddr   <= addr;
        pwdata  <= '0;
        @(posedge CLK);
        penable <= 1'b1;
        @(negedge CLK);
        if (!pready)
        begin
            $display("APB read of offset %h was stalled", addr);
            errors++;
        end
        data = prdata;
        err  = pslverr;
        @(posedge CLK);
        psel    <= 1'b0;
        penable <= 1'b0;
    endtask

    task automatic check_byte(input string name, input eeprom_byte_t exp, input eeprom_byte_t act);
        if (act !== exp)
        begin
            $display("Mismatch in %s: expected %h, actual %h", name, exp, act);
            errors++;
        end
    endtask

    task automatic check_addr(input string name, input eeprom_addr_t exp, input eeprom_addr_t act);
        if (act !== exp)
        begin
            $display("Mismatch in %s: expected %h, actual %h", name, exp, act);
            errors++;
        end
    endtask

    task automatic check_word(input string name, input apb_data_t exp, input apb_data_t act);
        if (act !== exp)
        begin
            $display("Mismatch in %s: expected %h, actual %h", name, exp, act);
            errors++;
        end
    endtask

    task automatic check_bit(input string name, input logic exp, input logic act);
        if (act !== exp)
        begin
            $display("Mismatch in %s: expected %b, actual %b", name, exp, act);
            errors++;
        end
    endtask

    task automatic poll_done(input string name, output apb_data_t status);
        int   start;
        logic err;
        start  = cycle_cnt;
        status = '0;
        while (!status[1] && (cycle_cnt - start) <= DONE_LIMIT)
            apb_read(REG_STATUS, status, err);
        if (!status[1])
        begin
            $display("%s: done bit not set within 50 bit times", name);
            errors++;
        end
    endtask

    task automatic check_bus_after(input string name, input int stops_exp);
        if (bus_busy || stop_cnt != stops_exp)
        begin
            $display("%s: job did not end with exactly one stop condition", name);
            errors++;
        end
    endtask

    task automatic run_job(input string name, input apb_data_t ctrl, output apb_data_t status);
        int   stops_before;
        int   waits;
        logic err;
        stops_before = stop_cnt;
        apb_write(REG_CTRL, ctrl, err, waits);
        poll_done(name, status);
        jobs_run++;
        starts_exp += (ctrl == 32'h2) ? 2 : 1;  // a read adds a repeated start
        check_bus_after(name, stops_before + 1);
    endtask

    task automatic report_test(input string name, input int errors_before);
        if (errors == errors_before)
        begin
            $display("test %s: ok", name);
            tests_passed++;
        end
        else
        begin
            $display("test %s: failed with %0d errors", name, errors - errors_before);
            tests_failed++;
        end
    endtask

    task automatic test_reset();
        int        e0;
        apb_data_t rd;
        logic      err;
        e0 = errors;
        apb_read(REG_STATUS, rd, err);
        check_word("reset status", 32'h0, rd);
        apb_read(REG_ADDR, rd, err);
        check_word("reset address", 32'h0, rd);
        apb_read(REG_WDATA, rd, err);
        check_word("reset write data", 32'h0, rd);
        check_bit("reset scl", 1'b1, scl);
        check_bit("reset sda", 1'b1, sda);
        report_test("reset state", e0);
    endtask

    task automatic write_then_read(input eeprom_addr_t addr);
        eeprom_byte_t data;
        apb_data_t    rd;
        apb_data_t    status;
        logic         err;
        int           waits;
        data = i_model.mem[addr] ^ eeprom_byte_t'($urandom_range(255, 1));  // always a new value
        apb_write(REG_ADDR, apb_data_t'(addr), err, waits);
        apb_write(REG_WDATA, apb_data_t'(data), err, waits);
        run_job("write job", 32'h1, status);
        check_word("write job status", 32'h2, status);
        check_byte("model memory", data, i_model.mem[addr]);
        apb_read(REG_ADDR, rd, err);
        check_addr("address register", addr, eeprom_addr_t'(rd));
        run_job("read job", 32'h2, status);
        check_word("read job status", 32'h2, status);
        apb_read(REG_RDATA, rd, err);
        check_byte("read data", data, eeprom_byte_t'(rd));
    endtask

    task automatic test_write_read();
        int e0;
        e0 = errors;
        write_then_read(11'h000);
        write_then_read(11'h7FF);
        for (int i = 0; i < N_RANDOM; i++)
            write_then_read(eeprom_addr_t'($urandom));
        report_test("write then read back", e0);
    endtask

    task automatic test_registers();
        int        e0;
        int        waits;
        apb_data_t rd;
        logic      err;
        e0 = errors;
        apb_write(REG_ADDR, 32'hFFFF_FFFF, err, waits);
        check_bit("address write pslverr", 1'b0, err);
        apb_read(REG_ADDR, rd, err);
        check_word("address register width", 32'h0000_07FF, rd);
        apb_write(REG_WDATA, 32'hFFFF_FFFF, err, waits);
        apb_read(REG_WDATA, rd, err);
        check_word("write data register width", 32'h0000_00FF, rd);
        apb_read(5'h14, rd, err);
        check_bit("unmapped read pslverr", 1'b1, err);
        apb_write(5'h1C, 32'h1, err, waits);
        check_bit("unmapped write pslverr", 1'b1, err);
        apb_write(REG_STATUS, 32'h7, err, waits);
        check_bit("status write pslverr", 1'b1, err);
        apb_read(REG_CTRL, rd, err);
        check_bit("control read pslverr", 1'b1, err);
        apb_read(REG_STATUS, rd, err);
        check_bit("status read pslverr", 1'b0, err);
        check_word("status after bad accesses", 32'h0, rd);
        report_test("register access", e0);
    endtask

    task automatic test_backpressure();
        int           e0;
        int           waits;
        int           stops_before;
        eeprom_addr_t addr;
        eeprom_byte_t data;
        apb_data_t    rd;
        logic         err;
        e0   = errors;
        addr = eeprom_addr_t'($urandom);
        data = i_model.mem[addr] ^ eeprom_byte_t'($urandom_range(255, 1));
        apb_write(REG_ADDR, apb_data_t'(addr), err, waits);
        apb_write(REG_WDATA, apb_data_t'(data), err, waits);
        stops_before = stop_cnt;
        apb_write(REG_CTRL, 32'h1, err, waits);
        apb_write(REG_CTRL, 32'h2, err, waits);  // must wait for the write job
        if (waits == 0)
        begin
            $display("back-pressure: second CTRL write was not held off while busy");
            errors++;
        end
        apb_read(REG_STATUS, rd, err);
        check_word("status after stalled write", 32'h3, rd);
        poll_done("back-pressure", rd);
        check_word("second job status", 32'h2, rd);
        jobs_run   += 2;
        starts_exp += 3;
        check_bus_after("back-pressure", stops_before + 2);
        check_byte("model memory", data, i_model.mem[addr]);
        apb_read(REG_RDATA, rd, err);
        check_byte("read data", data, eeprom_byte_t'(rd));
        report_test("back-pressure", e0);
    endtask

    task automatic test_nack();
        int           e0;
        int           waits;
        eeprom_addr_t addr;
        eeprom_byte_t old;
        apb_data_t    rd;
        logic         err;
        e0   = errors;
        addr = eeprom_addr_t'($urandom);
        old  = i_model.mem[addr];
        apb_write(REG_ADDR, apb_data_t'(addr), err, waits);
        apb_write(REG_WDATA, apb_data_t'(~old), err, waits);
        @(posedge CLK);
        nack_ctrl <= 1'b1;
        run_job("missing ack", 32'h1, rd);
        check_word("nack status", 32'h6, rd);
        check_byte("memory untouched", old, i_model.mem[addr]);
        apb_read(REG_STATUS, rd, err);
        check_word("status after clear", 32'h0, rd);
        @(posedge CLK);
        nack_ctrl <= 1'b0;
        report_test("missing acknowledge", e0);
    endtask

    task automatic test_bus_rules();
        int e0;
        e0 = errors;
        if (stop_cnt != jobs_run)
        begin
            $display("bus rules: %0d stop conditions seen for %0d jobs", stop_cnt, jobs_run);
            errors++;
        end
        if (start_cnt != starts_exp)
        begin
            $display("bus rules: %0d start conditions seen, %0d expected", start_cnt, starts_exp);
            errors++;
        end
        if (bus_busy)
        begin
            $display("bus rules: bus still open at the end of the run");
            errors++;
        end
        report_test("bus rules", e0);
    endtask

    initial
    begin
        #(WATCHDOG_NS);
        $display("timeout: run did not finish within %0d ns", WATCHDOG_NS);
        $display("Verification failed");
        $finish;
    end

    initial
    begin
        seed      = $urandom(32'h85b8_ae4d);
        RESET     = 1'b1;
        psel      = 1'b0;
        penable   = 1'b0;
        pwrite    = 1'b0;
        paddr     = '0;
        pwdata    = '0;
        nack_ctrl = 1'b0;
        repeat (4) @(posedge CLK);
        RESET <= 1'b0;
        test_reset();
        test_write_read();
        test_registers();
        test_backpressure();
        test_nack();
        test_bus_rules();
        $display("tests passed: %0d, tests failed: %0d", tests_passed, tests_failed);
        if (errors == 0 && tests_failed == 0)
            $display("Verification passed");
        else
            $display("Verification failed");
        $finish;
    end

endmodule

`default_nettype wire

// File: tb_eeprom_model.sv
`timescale 1ns/100ps
`default_nettype none

module tb_eeprom_model
    import eeprom_pkg::*;
(
    input  wire logic scl,
    inout  wire       sda,
    input  wire logic nack_ctrl   // refuse the device code
);

    typedef enum logic [2:0] {
        M_IDLE,
        M_CTRL,
        M_ADDR,
        M_DATA_IN,
        M_DATA_OUT
    } model_state_e;

    eeprom_byte_t mem [0:2047];
    model_state_e state = M_IDLE;
    eeprom_byte_t shreg = '0;
    eeprom_addr_t ptr = '0;
    logic [2:0]   block_sel = '0;  // address bits 10 to 8 from the control byte
    logic         rw = 1'b0;
    logic         ack;
    logic         drive_low = 1'b0;
    int           bitcnt = 0;

    assign sda = drive_low ? 1'b0 : 1'bz;

    initial
    begin
        for (int i = 0; i < 2048; i++)
            mem[i] = 8'(i) ^ 8'(i >> 3);
    end

    // start and repeated start
    always @(negedge sda)
    begin
        if (scl === 1'b1)
        begin
            state     = M_CTRL;
            bitcnt    = 0;
            drive_low = 1'b0;
        end
    end

    always @(posedge sda)
    begin
        if (scl === 1'b1)
        begin
            state     = M_IDLE;  // stop
            drive_low = 1'b0;
        end
    end

    always @(posedge scl)
    begin
        case (state)
            M_CTRL, M_ADDR, M_DATA_IN:
            begin
                if (bitcnt < 8)
                    shreg = {shreg[6:0], sda};
                bitcnt++;
            end
            M_DATA_OUT:
            begin
                if (bitcnt < 8)
                    bitcnt++;
                else if (sda === 1'b0)
                begin
                    ptr    = ptr + 11'd1;  // master wants another byte
                    shreg  = mem[ptr];
                    bitcnt = 0;
                end
                else
                    state = M_IDLE;
            end
            default: ;
        endcase
    end

    always @(negedge scl)
    begin
        case (state)
            M_CTRL, M_ADDR, M_DATA_IN:
            begin
                if (bitcnt == 8)
                begin
                    ack = 1'b1;
                    case (state)
                        M_CTRL:
                        begin
                            ack       = (shreg[7:4] == EEPROM_DEV_CODE) && !nack_ctrl;
                            block_sel = shreg[3:1];
                            rw        = shreg[0];
                        end
                        M_ADDR:
                            ptr = {block_sel, shreg};
                        default:
                        begin
                            mem[ptr] = shreg;  // stored at once
                            ptr      = ptr + 11'd1;
                        end
                    endcase
                    drive_low = ack;
                    if (!ack)
                        state = M_IDLE;
                end
                else if (bitcnt == 9)
                begin
                    drive_low = 1'b0;
                    bitcnt    = 0;
                    if (state == M_CTRL && rw)
                    begin
                        state     = M_DATA_OUT;
                        shreg     = mem[ptr];
                        drive_low = ~shreg[7];
                    end
                    else if (state == M_CTRL)
                        state = M_ADDR;
                    else
                        state = M_DATA_IN;
                end
            end
            M_DATA_OUT:
                drive_low = (bitcnt < 8) ? ~shreg[7 - bitcnt] : 1'b0;
            default: ;
        endcase
    end

endmodule

`default_nettype wire

// File: vlog.f
eeprom_pkg.sv
eeprom_apb_regs.sv
eeprom_xfer_ctrl.sv
i2c_bit_engine.sv
eeprom_master_top.sv
tb_eeprom_model.sv
tb_eeprom_master.sv
